/* compile.f */
+incdir+src
src/slap_pkg.sv
src/video_timing.sv
src/cpu_reg_decode.sv
src/scroll_adder.sv
src/layer_mixer.sv
src/slap_video_top.sv
testbench/slap_assertions.sv
testbench/tb_slap_video.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_slap_video
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_slap_video.sv */
// Testbench for the Slap Fight video backbone
// reset and sync spacing, then a table of layer codes, scroll and flip
// settings checked against a palette model filled from xorshift

`timescale 1ns/10ps
`include "slap_defines.svh"

module tb_slap_video;

	localparam int NROWS = 10;
	localparam int FRAME = `SLAP_H_TOTAL * `SLAP_V_TOTAL;   // cycles per frame
	localparam int WATCHDOG_NS = (NROWS + 4) * FRAME * 10;   // a frame per row, margin

	typedef struct packed {
		slap_pkg::pix_code_t fg, sp, bg;
		slap_pkg::hcoord_t   hs;
		slap_pkg::vcoord_t   vs;
		logic                flip;
		logic [1:0]          where;   // 0 visible, 1 hblank, 2 vblank
		logic [1:0]          pal_op;  // 0 none, 1 even byte only, 2 full entry
		slap_pkg::pix_code_t sel;     // code the priority rule picks
	} row_t;

	// fg sp bg hscroll vscroll flip where pal_op selected
	row_t rows [NROWS] = '{
		{8'h05, 8'h23, 8'h41, 9'h000, 8'h00, 1'b0, 2'd0, 2'd0, 8'h05},  // fg pen 1
		{8'h08, 8'h0C, 8'h41, 9'h010, 8'h20, 1'b0, 2'd0, 2'd0, 8'h0C},  // fg clear, sprite pen C
		{8'hFC, 8'hA0, 8'h5B, 9'h1F0, 8'hF0, 1'b0, 2'd0, 2'd0, 8'h5B},  // both clear, sums wrap
		{8'h83, 8'h0F, 8'h77, 9'h123, 8'h45, 1'b1, 2'd0, 2'd0, 8'h83},  // flipped
		{8'h00, 8'h01, 8'h02, 9'h1FF, 8'hFF, 1'b1, 2'd0, 2'd0, 8'h01},
		{8'h3E, 8'h91, 8'hC4, 9'h055, 8'h66, 1'b0, 2'd1, 2'd0, 8'h3E},  // hblank, black
		{8'h12, 8'h34, 8'h56, 9'h0AA, 8'h11, 1'b1, 2'd2, 2'd0, 8'h12},  // vblank, black
		{8'h5A, 8'h5A, 8'h5A, 9'h000, 8'h00, 1'b0, 2'd0, 2'd1, 8'h5A},  // half write, old entry
		{8'h5A, 8'h5A, 8'h5A, 9'h000, 8'h00, 1'b0, 2'd0, 2'd2, 8'h5A},  // new entry
		{8'hC0, 8'h00, 8'h00, 9'h100, 8'h80, 1'b0, 2'd0, 2'd2, 8'h00}   // bg index 0
	};

	logic pixel_clk;
	logic RESET_n;
	slap_pkg::cpu_wr_t   cpu_wr;
	slap_pkg::pix_code_t fg, sp, bg;
	slap_pkg::hcoord_t   hpix_o, bg_h_o;
	slap_pkg::vcoord_t   vpix_o, bg_v_o;
	slap_pkg::rgb_t      rgb_o;
	logic hsync_o, vsync_o, hblank_o, vblank_o;

	slap_pkg::rgb_t pal_model [`SLAP_PAL_DEPTH];
	logic [31:0] rnd = 32'd23;       // xorshift state
	int unsigned cyc = 0;            // enabled edges since reset
	int tests = 0;
	int failed = 0;
	int checks = 0;
	int errors = 0;

	slap_video_top DUT (
		.pixel_clk (pixel_clk), .RESET_n (RESET_n), .cpu_wr_i (cpu_wr),
		.fg_i (fg), .sp_i (sp), .bg_i (bg),
		.hpix_o (hpix_o), .vpix_o (vpix_o), .bg_h_o (bg_h_o), .bg_v_o (bg_v_o),
		.rgb_o (rgb_o), .hsync_o (hsync_o), .vsync_o (vsync_o),
		.hblank_o (hblank_o), .vblank_o (vblank_o)
	);

	bind video_timing slap_assertions u_sva (.pixel_clk, .RESET_n, .raster_i(raster_o));

	initial begin
		pixel_clk = 1'b0;
		forever #5 pixel_clk = ~pixel_clk;
	end

	always @(posedge pixel_clk) begin
		if (RESET_n)
			cyc <= cyc + 1;
	end

	// ========================================
	// helpers
	// ========================================
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// counter state behind hpix_o / vpix_o
	function automatic int unsigned line_pixel();
		return (cyc == 0) ? 0 : (cyc - 1) % `SLAP_H_TOTAL;
	endfunction

	function automatic int unsigned frame_line();
		return (cyc == 0) ? 0 : ((cyc - 1) / `SLAP_H_TOTAL) % `SLAP_V_TOTAL;
	endfunction

	function automatic bit at_target(input logic [1:0] where, input int unsigned ph,
			input int unsigned pv);
		case (where)
			2'd1:    return ph >= `SLAP_H_ACTIVE + 8 && ph < `SLAP_H_TOTAL - 8
				&& pv < `SLAP_V_ACTIVE;
			2'd2:    return ph < `SLAP_H_ACTIVE - 8 && pv >= `SLAP_V_ACTIVE
				&& pv < `SLAP_V_TOTAL - 1;
			default: return ph < `SLAP_H_ACTIVE - 8 && pv < `SLAP_V_ACTIVE;
		endcase
	endfunction

	function automatic slap_pkg::cpu_addr_t pal_addr(input logic [7:0] idx, input logic odd);
		return slap_pkg::cpu_addr_t'(`SLAP_PAL_BASE + 2 * idx + odd);
	endfunction

	task automatic check_rgb(input slap_pkg::rgb_t got, input slap_pkg::rgb_t exp,
			input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns: %s got %03h expected %03h", $time, what, got, exp);
		end
	endtask

	task automatic check_coord(input slap_pkg::hcoord_t h, input slap_pkg::hcoord_t h_exp,
			input slap_pkg::vcoord_t v, input slap_pkg::vcoord_t v_exp, input string what);
		checks++;
		if (h !== h_exp || v !== v_exp) begin
			errors++;
			$display("[ERROR] %0t ns: %s got h=%03h v=%02h expected h=%03h v=%02h",
				$time, what, h, v, h_exp, v_exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int errs0);
		tests++;
		if (errors != errs0) begin
			failed++;
			$display("%s: %0d mismatches", name, errors - errs0);
		end else
			$display("%s: ok", name);
	endtask

	// one-cycle strobe, decode takes it on the following edge
	task automatic bus_write(input slap_pkg::cpu_addr_t addr, input slap_pkg::cpu_data_t data);
		@(posedge pixel_clk);
		cpu_wr <= '{addr: addr, data: data, we: 1'b1};
		@(posedge pixel_clk);
		cpu_wr.we <= 1'b0;
	endtask

	task automatic write_palette_entry(input logic [7:0] idx, input logic [11:0] bits);
		bus_write(pal_addr(idx, 1'b0), bits[7:0]);           // red 7:4, green 3:0
		bus_write(pal_addr(idx, 1'b1), {4'h0, bits[11:8]});  // blue, commits entry
		pal_model[idx] = '{r: bits[7:4], g: bits[3:0], b: bits[11:8]};
	endtask

	// time from one sync rise to the next, checked to the exact cycle
	task automatic sync_spacing(input logic use_v, input int unsigned period, input string name);
		logic prev;
		logic cur;
		int errs0;
		errs0 = errors;
		@(negedge pixel_clk);
		cur = use_v ? vsync_o : hsync_o;
		do begin
			prev = cur;
			@(negedge pixel_clk);
			cur = use_v ? vsync_o : hsync_o;
		end while (!(cur && !prev));
		repeat (period - 1) @(negedge pixel_clk);
		check_flag(use_v ? vsync_o : hsync_o, 1'b0, {name, " low just before next rise"});
		@(negedge pixel_clk);
		check_flag(use_v ? vsync_o : hsync_o, 1'b1, {name, " rises one period later"});
		report_test(name, errs0);
	endtask

	// ========================================
	// one table row
	// ========================================
	task automatic run_row(input row_t r, input int n);
		int unsigned ph;
		int unsigned pv;
		slap_pkg::hcoord_t h_exp;
		slap_pkg::vcoord_t v_exp;
		logic blk;
		int errs0;
		errs0 = errors;
		if (r.pal_op != 2'd0) begin
			rnd = xorshift32(rnd);
			if (r.pal_op == 2'd1)
				bus_write(pal_addr(r.sel.raw, 1'b0), rnd[7:0]);   // even half only
			else
				write_palette_entry(r.sel.raw, rnd[11:0]);
		end
		bus_write(slap_pkg::cpu_addr_t'(`SLAP_REG_HSCRL_LO), r.hs[7:0]);
		bus_write(slap_pkg::cpu_addr_t'(`SLAP_REG_HSCRL_HI), {7'd0, r.hs[8]});
		bus_write(slap_pkg::cpu_addr_t'(`SLAP_REG_VSCRL), r.vs);
		bus_write(slap_pkg::cpu_addr_t'(`SLAP_REG_FLIP), {7'd0, r.flip});
		repeat (2) @(posedge pixel_clk);   // new flip reaches the raster
		do begin
			@(negedge pixel_clk);
			ph = line_pixel();
			pv = frame_line();
		end while (!at_target(r.where, ph, pv));
		// flipped coords are the complement of the counts
		h_exp = slap_pkg::hcoord_t'(ph) ^ {`SLAP_HC_W{r.flip}};
		v_exp = slap_pkg::vcoord_t'(pv) ^ {`SLAP_VC_W{r.flip}};
		check_coord(hpix_o, h_exp, vpix_o, v_exp, "raster coords");
		check_flag(hblank_o, ph >= `SLAP_H_ACTIVE, "hblank");
		check_flag(vblank_o, pv >= `SLAP_V_ACTIVE, "vblank");
		@(posedge pixel_clk);
		fg <= r.fg;
		sp <= r.sp;
		bg <= r.bg;
		@(negedge pixel_clk);
		check_coord(bg_h_o, slap_pkg::hcoord_t'(h_exp + r.hs),
			bg_v_o, slap_pkg::vcoord_t'(v_exp + r.vs), "bg scroll sum");
		// blank at the pixel the codes meet, one step on in the same line
		blk = (ph + 1 >= `SLAP_H_ACTIVE) || (pv >= `SLAP_V_ACTIVE);
		repeat (2) @(negedge pixel_clk);   // colour register, palette read
		check_rgb(rgb_o, blk ? slap_pkg::rgb_t'(0) : pal_model[r.sel.raw], "mixer rgb");
		report_test($sformatf("table row %0d", n), errs0);
	endtask

	// ========================================
	// main sequence
	// ========================================
	initial begin
		int errs0;
		RESET_n = 1'b0;
		cpu_wr = '0;
		fg = '0;
		sp = '0;
		bg = '0;
		repeat (10) @(posedge pixel_clk);
		RESET_n <= 1'b1;
		@(negedge pixel_clk);
		errs0 = errors;
		check_flag(hsync_o, 1'b0, "hsync after reset");
		check_flag(vsync_o, 1'b0, "vsync after reset");
		check_flag(hblank_o, 1'b0, "hblank after reset");
		check_flag(vblank_o, 1'b0, "vblank after reset");
		check_coord(hpix_o, '0, vpix_o, '0, "raster after reset");
		report_test("reset state", errs0);
		sync_spacing(1'b0, `SLAP_H_TOTAL, "hsync spacing");
		sync_spacing(1'b1, FRAME, "vsync spacing");
		for (int i = 0; i < `SLAP_PAL_DEPTH; i++) begin
			rnd = xorshift32(rnd);
			write_palette_entry(8'(i), rnd[11:0]);
		end
		for (int i = 0; i < NROWS; i++)
			run_row(rows[i], i);
		$display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
			tests, failed, checks, errors, DUT.u_timing.u_sva.fails);
		if (errors == 0 && DUT.u_timing.u_sva.fails == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* testbench/slap_assertions.sv */
// Raster checks bound into the video timing
// sync sits inside blank, vblank only moves at the end of a line

`timescale 1ns/10ps

module slap_assertions (
	input logic              pixel_clk,
	input logic              RESET_n,
	input slap_pkg::raster_t raster_i
);

	int unsigned fails = 0;     // failed property count

	// hsync window lies inside horizontal blank
	hsync_in_hblank: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		raster_i.hsync |-> raster_i.hblank)
		else begin
			fails++;
			$error("hsync active outside hblank");
		end

	vsync_in_vblank: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		raster_i.vsync |-> raster_i.vblank)
		else begin
			fails++;
			$error("vsync active outside vblank");
		end

	// line steps at the h wrap, so the pixel before is blanked
	vblank_at_line_end: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		$changed(raster_i.vblank) |-> $past(raster_i.hblank))
		else begin
			fails++;
			$error("vblank changed in mid line");
		end

endmodule

/* src/slap_video_top.sv */
// Slap Fight video backbone, top level
// timing, CPU register decode, background scroll adder and colour mixer;
// the layer generators sit outside and use the coordinates given out here

`timescale 1ns/10ps

module slap_video_top (
	input  logic                pixel_clk,
	input  logic                RESET_n,
	input  slap_pkg::cpu_wr_t   cpu_wr_i,
	input  slap_pkg::pix_code_t fg_i,
	input  slap_pkg::pix_code_t sp_i,
	input  slap_pkg::pix_code_t bg_i,
	output slap_pkg::hcoord_t   hpix_o,
	output slap_pkg::vcoord_t   vpix_o,
	output slap_pkg::hcoord_t   bg_h_o,
	output slap_pkg::vcoord_t   bg_v_o,
	output slap_pkg::rgb_t      rgb_o,
	output logic                hsync_o,
	output logic                vsync_o,
	output logic                hblank_o,
	output logic                vblank_o
);

	slap_pkg::raster_t raster;
	slap_pkg::scroll_t scroll;
	slap_pkg::pal_wr_t pal_wr;
	logic              flip;
	logic              blank;

	video_timing u_timing (
		.pixel_clk (pixel_clk),
		.RESET_n   (RESET_n),
		.flip_i    (flip),
		.raster_o  (raster)
	);

	cpu_reg_decode u_regs (
		.pixel_clk (pixel_clk),
		.RESET_n   (RESET_n),
		.cpu_wr_i  (cpu_wr_i),
		.scroll_o  (scroll),
		.flip_o    (flip),
		.pal_wr_o  (pal_wr)
	);

	scroll_adder u_scroll (
		.pixel_clk (pixel_clk),
		.RESET_n   (RESET_n),
		.raster_i  (raster),
		.scroll_i  (scroll),
		.bg_h_o    (bg_h_o),
		.bg_v_o    (bg_v_o)
	);

	assign blank = raster.hblank | raster.vblank;   // either blank kills colour

	layer_mixer u_mixer (
		.pixel_clk (pixel_clk),
		.RESET_n   (RESET_n),
		.fg_i      (fg_i),
		.sp_i      (sp_i),
		.bg_i      (bg_i),
		.pal_wr_i  (pal_wr),
		.blank_i   (blank),
		.rgb_o     (rgb_o)
	);

	// raster out to the pins and the layer generators
	assign hpix_o   = raster.h;
	assign vpix_o   = raster.v;
	assign hsync_o  = raster.hsync;
	assign vsync_o  = raster.vsync;
	assign hblank_o = raster.hblank;
	assign vblank_o = raster.vblank;

endmodule

/* src/layer_mixer.sv */
// Layer priority mixer and colour lookup
// fg over sprites over background by pen transparency, then a
// 256 x 12 palette RAM lookup, black while blanked

`timescale 1ns/10ps
`include "slap_defines.svh"

module layer_mixer (
	input  logic                pixel_clk,
	input  logic                RESET_n,
	input  slap_pkg::pix_code_t fg_i,
	input  slap_pkg::pix_code_t sp_i,
	input  slap_pkg::pix_code_t bg_i,
	input  slap_pkg::pal_wr_t   pal_wr_i,
	input  logic                blank_i,    // hblank | vblank
	output slap_pkg::rgb_t      rgb_o
);

	slap_pkg::pix_code_t col_d;
	slap_pkg::pix_code_t col_q;     // colour register
	logic                blank_q;   // blank, stage 1
	slap_pkg::rgb_t      rgb_q;     // stage 2
	slap_pkg::rgb_t      pal_mem [`SLAP_PAL_DEPTH];

	// ========================================
	// priority select
	// ========================================
	always_comb begin
		if (fg_i.chr.pen != 2'b00)
			col_d = fg_i;               // char pen in 1:0
		else if (sp_i.spr.pen != 4'h0)
			col_d = sp_i;               // sprite pen in 3:0
		else
			col_d = bg_i;               // bg always shows through
	end

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			col_q   <= '0;
			blank_q <= 1'b0;
		end else begin
			col_q   <= col_d;
			blank_q <= blank_i;         // follows the code down the pipe
		end
	end

	// ========================================
	// palette RAM
	// ========================================
	always_ff @(posedge pixel_clk) begin
		if (pal_wr_i.we)
			pal_mem[pal_wr_i.idx] <= pal_wr_i.rgb;
	end

	// registered read, two cycles after the codes
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n)
			rgb_q <= '0;
		else if (blank_q)
			rgb_q <= '0;                // black outside visible area
		else
			rgb_q <= pal_mem[col_q.raw];
	end

	assign rgb_o = rgb_q;

endmodule

/* src/scroll_adder.sv */
// Background scroll adder
// adds the scroll registers to the raster coordinates, giving the
// coordinates the background tile generator addresses with

`timescale 1ns/10ps

module scroll_adder (
	input  logic              pixel_clk,
	input  logic              RESET_n,
	input  slap_pkg::raster_t raster_i,
	input  slap_pkg::scroll_t scroll_i,
	output slap_pkg::hcoord_t bg_h_o,
	output slap_pkg::vcoord_t bg_v_o
);

	slap_pkg::hcoord_t h_sum;
	slap_pkg::vcoord_t v_sum;

	// ========================================
	// wrapped sums
	// ========================================
	// carry out of the top bit is dropped, so h wraps at 512 and v at 256
	assign h_sum = raster_i.h + scroll_i.h;
	assign v_sum = raster_i.v + scroll_i.v;

	// one cycle behind the raster coordinates
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			bg_h_o <= '0;
			bg_v_o <= '0;
		end else begin
			bg_h_o <= h_sum;
			bg_v_o <= v_sum;
		end
	end

endmodule

/* src/cpu_reg_decode.sv */
// CPU register decode for the video backbone
// scroll registers and flip latch in the register page, palette bytes
// paired into one 12-bit palette write

`timescale 1ns/10ps
`include "slap_defines.svh"

module cpu_reg_decode (
	input  logic              pixel_clk,
	input  logic              RESET_n,
	input  slap_pkg::cpu_wr_t cpu_wr_i,
	output slap_pkg::scroll_t scroll_o,
	output logic              flip_o,
	output slap_pkg::pal_wr_t pal_wr_o
);

	localparam slap_pkg::cpu_addr_t REG_HLO  = slap_pkg::cpu_addr_t'(`SLAP_REG_HSCRL_LO);
	localparam slap_pkg::cpu_addr_t REG_HHI  = slap_pkg::cpu_addr_t'(`SLAP_REG_HSCRL_HI);
	localparam slap_pkg::cpu_addr_t REG_V    = slap_pkg::cpu_addr_t'(`SLAP_REG_VSCRL);
	localparam slap_pkg::cpu_addr_t REG_FLIP = slap_pkg::cpu_addr_t'(`SLAP_REG_FLIP);
	localparam slap_pkg::cpu_addr_t PAL_BASE = slap_pkg::cpu_addr_t'(`SLAP_PAL_BASE);

	slap_pkg::cpu_addr_t pal_off;   // byte offset into palette area
	logic                pal_hit;
	logic [7:0]          even_q;    // red/green byte waiting for its blue half
	logic [7:0]          idx_q;
	slap_pkg::rgb_t      rgb_q;
	logic                we_q;

	// ========================================
	// register page
	// ========================================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			scroll_o <= '0;
			flip_o   <= 1'b0;
		end else if (cpu_wr_i.we) begin
			case (cpu_wr_i.addr)
				REG_HLO:  scroll_o.h[7:0] <= cpu_wr_i.data;
				REG_HHI:  scroll_o.h[8]   <= cpu_wr_i.data[0];
				REG_V:    scroll_o.v      <= cpu_wr_i.data;
				REG_FLIP: flip_o          <= cpu_wr_i.data[0];
				default:  ;                     // palette or unmapped
			endcase
		end
	end

	// ========================================
	// palette byte pairing
	// ========================================
	assign pal_off = cpu_wr_i.addr - PAL_BASE;
	assign pal_hit = cpu_wr_i.we && (cpu_wr_i.addr >= PAL_BASE);

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n)
			we_q <= 1'b0;
		else
			we_q <= pal_hit && pal_off[0];     // odd byte completes entry
	end

	always_ff @(posedge pixel_clk) begin
		if (pal_hit && !pal_off[0])
			even_q <= cpu_wr_i.data;           // r in 7:4, g in 3:0
		if (pal_hit && pal_off[0]) begin
			idx_q <= pal_off[8:1];
			rgb_q <= '{r: even_q[7:4], g: even_q[3:0], b: cpu_wr_i.data[3:0]};
		end
	end

	assign pal_wr_o = '{idx: idx_q, rgb: rgb_q, we: we_q};

endmodule

/* src/video_timing.sv */
// Slap Fight video timing
// pixel and line counters, screen flip on the given-out coordinates,
// sync and blank from plain counter compares
// everything leaves through one registered raster bundle

`timescale 1ns/10ps
`include "slap_defines.svh"

module video_timing (
	input  logic              pixel_clk,
	input  logic              RESET_n,
	input  logic              flip_i,     // screen flip level
	output slap_pkg::raster_t raster_o
);

	typedef logic [`SLAP_VCNT_W-1:0] vcnt_t;

	// compare points, sized to the counters
	localparam slap_pkg::hcoord_t H_LAST   = slap_pkg::hcoord_t'(`SLAP_H_TOTAL - 1);
	localparam slap_pkg::hcoord_t H_ACT    = slap_pkg::hcoord_t'(`SLAP_H_ACTIVE);
	localparam slap_pkg::hcoord_t HS_START = slap_pkg::hcoord_t'(`SLAP_HSYNC_START);
	localparam slap_pkg::hcoord_t HS_END   = slap_pkg::hcoord_t'(`SLAP_HSYNC_END);
	localparam vcnt_t             V_LAST   = vcnt_t'(`SLAP_V_TOTAL - 1);
	localparam vcnt_t             V_ACT    = vcnt_t'(`SLAP_V_ACTIVE);
	localparam vcnt_t             VS_START = vcnt_t'(`SLAP_VSYNC_START);
	localparam vcnt_t             VS_END   = vcnt_t'(`SLAP_VSYNC_END);

	slap_pkg::hcoord_t hcnt;    // pixel within line
	vcnt_t             vcnt;    // line within frame
	logic              h_wrap;
	logic              v_wrap;
	logic              hsync_d;
	logic              vsync_d;
	logic              hblank_d;
	logic              vblank_d;

	// ========================================
	// counters
	// ========================================
	assign h_wrap = (hcnt == H_LAST);
	assign v_wrap = (vcnt == V_LAST);

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			hcnt <= '0;
			vcnt <= '0;
		end else begin
			if (h_wrap) begin
				hcnt <= '0;
				// line steps only at end of line
				vcnt <= v_wrap ? '0 : vcnt + 1'b1;
			end else begin
				hcnt <= hcnt + 1'b1;
			end
		end
	end

	// ========================================
	// sync / blank compares
	// ========================================
	assign hsync_d  = (hcnt >= HS_START) && (hcnt < HS_END);
	assign vsync_d  = (vcnt >= VS_START) && (vcnt < VS_END);
	assign hblank_d = (hcnt >= H_ACT);     // right of visible area
	assign vblank_d = (vcnt >= V_ACT);     // below last visible line

	// coords and flags from the same counter state, so they stay aligned
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			raster_o <= '0;                    // same as count 0, flip off
		end else begin
			// flipped screen counts backwards, i.e. bitwise complement
			raster_o.h      <= hcnt ^ {$bits(slap_pkg::hcoord_t){flip_i}};
			raster_o.v      <= vcnt[$bits(slap_pkg::vcoord_t)-1:0]
				^ {$bits(slap_pkg::vcoord_t){flip_i}};
			raster_o.hsync  <= hsync_d;
			raster_o.vsync  <= vsync_d;
			raster_o.hblank <= hblank_d;
			raster_o.vblank <= vblank_d;
		end
	end

endmodule

/* src/slap_pkg.sv */
// Slap Fight video types
// coordinates, CPU write bus, raster bundle, layer pixel codes and colour

`include "slap_defines.svh"

package slap_pkg;

	typedef logic [`SLAP_HC_W-1:0]   hcoord_t;
	typedef logic [`SLAP_VC_W-1:0]   vcoord_t;
	typedef logic [`SLAP_ADDR_W-1:0] cpu_addr_t;
	typedef logic [`SLAP_DATA_W-1:0] cpu_data_t;

	// plain CPU write, strobe is high for one pixel_clk
	typedef struct packed {
		cpu_addr_t addr;
		cpu_data_t data;
		logic      we;
	} cpu_wr_t;

	typedef struct packed {
		hcoord_t h;     // 9 bit, bit 8 from its own register
		vcoord_t v;
	} scroll_t;

	typedef struct packed {
		hcoord_t h;     // flipped when screen flip set
		vcoord_t v;
		logic    hsync;
		logic    vsync;
		logic    hblank;
		logic    vblank;
	} raster_t;

	// ========================================
	// layer pixel code, two decodes of one byte
	// ========================================
	typedef struct packed {
		logic [5:0] pal;
		logic [1:0] pen;    // 0 = transparent
	} char_code_t;          // foreground

	typedef struct packed {
		logic [3:0] pal;
		logic [3:0] pen;    // 0 = transparent
	} spr_code_t;           // sprites and background

	typedef union packed {
		logic [7:0] raw;    // palette index as a whole
		char_code_t chr;
		spr_code_t  spr;
	} pix_code_t;

	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

	typedef struct packed {
		logic [7:0] idx;
		rgb_t       rgb;
		logic       we;     // one cycle
	} pal_wr_t;

endpackage

/* src/slap_defines.svh */
// Slap Fight video backbone constants
// raster geometry, sync windows, CPU register page and palette layout

`ifndef SLAP_DEFINES_SVH
`define SLAP_DEFINES_SVH

// ========================================
// raster geometry
// ========================================
`define SLAP_H_TOTAL       384     // pixel clocks per line
`define SLAP_H_ACTIVE      256     // visible pixels
`define SLAP_HSYNC_START   288     // hsync window, pixel counts
`define SLAP_HSYNC_END     320
`define SLAP_V_TOTAL       264     // lines per frame
`define SLAP_V_ACTIVE      224     // visible lines
`define SLAP_VSYNC_START   240     // vsync window, line counts
`define SLAP_VSYNC_END     244

// ========================================
// CPU bus map
// ========================================
`define SLAP_REG_HSCRL_LO  0       // hscroll bits 7:0
`define SLAP_REG_HSCRL_HI  1       // hscroll bit 8
`define SLAP_REG_VSCRL     2
`define SLAP_REG_FLIP      3       // bit 0 only
`define SLAP_PAL_BASE      'h200   // 256 entries x 2 bytes from here

// field widths
`define SLAP_ADDR_W        10
`define SLAP_DATA_W        8
`define SLAP_HC_W          9       // horizontal coordinate
`define SLAP_VC_W          8       // vertical coordinate
`define SLAP_VCNT_W        9       // line counter, 264 lines need 9 bits
`define SLAP_PAL_DEPTH     256

`endif
